/* source/bootControl.sv */
`timescale 1ns/1ps

module bootControl (
    input  logic                clock,
    input  logic                reset,
    input  logic                cfgWrite,   // single-cycle register write strobe
    input  logic [1:0]          cfgAddr,    // register select
    input  logic [31:0]         cfgData,    // write data
    input  fetchPkg::loaderStatus status,   // loader feedback
    output logic                loadStart,  // one-cycle kick to the loader
    output logic [fetchPkg::PROGRAM_INDEX_WIDTH-1:0] loadBase,
    output logic [15:0]         loadCount,
    output logic                bootActive  // fetch from boot rom while high
);

    logic controlWrite; // write hits the control register
    logic startRequest; // host asks for a load
    logic startAllowed; // loader free and count usable

    assign controlWrite = cfgWrite && (cfgAddr == fetchPkg::CFG_CONTROL);
    assign startRequest = controlWrite && cfgData[fetchPkg::CTRL_START_LOAD];
    // a start already in flight counts as busy, the loader sees it one edge later
    assign startAllowed = !status.busy && !loadStart && (loadCount != 16'd0);

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            loadBase   <= '0;
            loadCount  <= '0;
            bootActive <= 1'b1;  // core wakes up in the boot rom
            loadStart  <= 1'b0;
        end else begin
            loadStart <= startRequest && startAllowed; // pulse, else ignored
            if (cfgWrite) begin
                case (cfgAddr)
                    fetchPkg::CFG_LOAD_BASE: begin
                        loadBase <= cfgData[fetchPkg::PROGRAM_INDEX_WIDTH-1:0];
                    end
                    fetchPkg::CFG_LOAD_COUNT: begin
                        loadCount <= cfgData[15:0];
                    end
                    fetchPkg::CFG_CONTROL: begin
                        if (cfgData[fetchPkg::CTRL_END_BOOT]) begin
                            bootActive <= 1'b0; // sticky until reset
                        end
                    end
                    default: begin
                        // address 3 unmapped
                    end
                endcase
            end
        end
    end

    // only reset may bring the boot rom back
    bootStaysOff : assert property (
        @(posedge clock) disable iff (reset)
        !$rose(bootActive)
    );

    // start pulse never overlaps a running load
    noStartWhileBusy : assert property (
        @(posedge clock) disable iff (reset)
        loadStart |-> !status.busy
    );

endmodule

/* source/bootRom.sv */
`timescale 1ns/1ps

module bootRom (
    input  logic [fetchPkg::BOOT_INDEX_WIDTH-1:0] readIndex, // low pc bits
    output logic [31:0]                           readData   // boot word
);

    logic [4:0] registerNumber; // rd for the movi at this index

    // index 1 clears r0, index 32 clears r31
    assign registerNumber = readIndex[4:0] - 5'd1;

    // start-up sequence, movi rN, 0 for every architectural register
    always_comb begin
        readData = 32'd0;
        case (readIndex) inside
            [7'd1:7'd32]: begin
                readData = {
                    fetchPkg::OPCODE_MOVI, // opcode
                    registerNumber,        // rd
                    5'd0,                  // rs
                    5'd0,                  // rt
                    11'd0                  // immediate
                };
            end
            default: begin
                readData = 32'd0; // index 0 and the tail decode as nop
            end
        endcase
    end

endmodule

/* source/fetchPkg.sv */
package fetchPkg;

    // memory sizes
    localparam int BOOT_DEPTH = 128;                            // boot rom words
    localparam int BOOT_INDEX_WIDTH = $clog2(BOOT_DEPTH);       // 7 bits of pc
    localparam int PROGRAM_DEPTH = 256;                         // program store words
    localparam int PROGRAM_INDEX_WIDTH = $clog2(PROGRAM_DEPTH); // 8 bits of pc

    // opcodes known to this side of the core
    localparam logic [5:0] OPCODE_MOVI = 6'd26;                 // 6'b011010, move immediate

    // configuration register map
    localparam logic [1:0] CFG_LOAD_BASE = 2'd0;                // first program index to fill
    localparam logic [1:0] CFG_LOAD_COUNT = 2'd1;               // words to pull from disk
    localparam logic [1:0] CFG_CONTROL = 2'd2;                  // command bits below

    // control register bits
    localparam int CTRL_START_LOAD = 0;                         // kick off a disk load
    localparam int CTRL_END_BOOT = 1;                           // leave boot rom for good

    // instruction word layout, msb first
    //   31..26 opcode
    //   25..21 rd
    //   20..16 rs
    //   15..11 rt
    //   10..0  immediate
    // jumpTarget is bits 25..0, so it covers rd, rs, rt and immediate
    typedef struct packed {
        logic [5:0]  opcode;     // major opcode
        logic [4:0]  rd;         // destination register
        logic [4:0]  rs;         // first source
        logic [4:0]  rt;         // second source
        logic [10:0] immediate;  // short constant
        logic [25:0] jumpTarget; // absolute jump field
    } decodedInstr;

    // loader progress as seen by the register block and the host
    typedef struct packed {
        logic        busy;        // handshake in progress
        logic        done;        // last load reached its count
        logic [15:0] wordsLoaded; // words written since last start
    } loaderStatus;

endpackage

/* source/fetchTop.sv */
`timescale 1ns/1ps

module fetchTop (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  cfgWrite,   // host register write
    input  logic [1:0]            cfgAddr,
    input  logic [31:0]           cfgData,
    input  logic [31:0]           pc,         // fetch address
    output logic                  diskReq,    // disk handshake
    input  logic                  diskAck,
    input  logic [31:0]           diskData,
    output fetchPkg::decodedInstr fields,     // decoded instruction, one cycle after pc
    output logic                  bootActive, // boot rom selected
    output fetchPkg::loaderStatus status      // loader progress
);

    // register block to loader
    logic                                     loadStart;
    logic [fetchPkg::PROGRAM_INDEX_WIDTH-1:0] loadBase;
    logic [15:0]                              loadCount;

    // loader to program memory
    logic                                     writeEnable;
    logic [fetchPkg::PROGRAM_INDEX_WIDTH-1:0] writeIndex;
    logic [31:0]                              writeData;

    // fetch to memories and back
    logic [fetchPkg::BOOT_INDEX_WIDTH-1:0]    bootIndex;
    logic [31:0]                              bootWord;
    logic [fetchPkg::PROGRAM_INDEX_WIDTH-1:0] programIndex;
    logic [31:0]                              programWord;

    bootControl bootControlInst (
        .clock(clock), .reset(reset),
        .cfgWrite(cfgWrite), .cfgAddr(cfgAddr), .cfgData(cfgData),
        .status(status), .loadStart(loadStart),
        .loadBase(loadBase), .loadCount(loadCount), .bootActive(bootActive)
    );

    programLoader programLoaderInst (
        .clock(clock), .reset(reset),
        .loadStart(loadStart), .loadBase(loadBase), .loadCount(loadCount),
        .diskReq(diskReq), .diskAck(diskAck), .diskData(diskData),
        .writeEnable(writeEnable), .writeIndex(writeIndex), .writeData(writeData),
        .status(status)
    );

    programMemory programMemoryInst (
        .clock(clock),
        .writeEnable(writeEnable), .writeIndex(writeIndex), .writeData(writeData),
        .readIndex(programIndex), .readData(programWord)
    );

    bootRom bootRomInst (
        .readIndex(bootIndex), .readData(bootWord)
    );

    instructionFetch instructionFetchInst (
        .clock(clock), .reset(reset),
        .pc(pc), .bootActive(bootActive),
        .bootWord(bootWord), .programWord(programWord),
        .bootIndex(bootIndex), .programIndex(programIndex),
        .fields(fields)
    );

endmodule

/* source/instructionFetch.sv */
`timescale 1ns/1ps

module instructionFetch (
    input  logic        clock,
    input  logic        reset,
    input  logic [31:0] pc,          // word address
    input  logic        bootActive,  // source select
    input  logic [31:0] bootWord,    // from boot rom
    input  logic [31:0] programWord, // from program memory
    output logic [fetchPkg::BOOT_INDEX_WIDTH-1:0]    bootIndex,
    output logic [fetchPkg::PROGRAM_INDEX_WIDTH-1:0] programIndex,
    output fetchPkg::decodedInstr fields  // registered split word
);

    logic [31:0] selectedWord; // word picked for this pc

    // both memories see the pc every cycle, upper bits alias
    assign bootIndex    = pc[fetchPkg::BOOT_INDEX_WIDTH-1:0];
    assign programIndex = pc[fetchPkg::PROGRAM_INDEX_WIDTH-1:0];

    assign selectedWord = bootActive ? bootWord : programWord;

    // one-cycle fetch, a new pc every cycle
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            fields <= '0;
        end else begin
            fields.opcode     <= selectedWord[31:26];
            fields.rd         <= selectedWord[25:21];
            fields.rs         <= selectedWord[20:16];
            fields.rt         <= selectedWord[15:11];
            fields.immediate  <= selectedWord[10:0];
            fields.jumpTarget <= selectedWord[25:0]; // overlaps the register fields
        end
    end

    // boot rom output is fully defined, so a boot fetch is never x
    bootFetchKnown : assert property (
        @(posedge clock) disable iff (reset)
        $past(bootActive) |-> !$isunknown(fields)
    );

endmodule

/* source/programLoader.sv */
`timescale 1ns/1ps

module programLoader (
    input  logic                clock,
    input  logic                reset,
    input  logic                loadStart,   // one-cycle start from the register block
    input  logic [fetchPkg::PROGRAM_INDEX_WIDTH-1:0] loadBase,
    input  logic [15:0]         loadCount,
    output logic                diskReq,     // four-phase request
    input  logic                diskAck,     // four-phase acknowledge
    input  logic [31:0]         diskData,    // valid while diskAck high
    output logic                writeEnable, // one pulse per word
    output logic [fetchPkg::PROGRAM_INDEX_WIDTH-1:0] writeIndex,
    output logic [31:0]         writeData,
    output fetchPkg::loaderStatus status
);

    typedef enum logic [1:0] {
        idle,        // nothing loaded since reset
        request,     // diskReq high, waiting for ack
        waitRelease, // req dropped, waiting for ack low
        finished     // count reached, done held
    } loaderState;

    loaderState state;
    logic [fetchPkg::PROGRAM_INDEX_WIDTH-1:0] cursor; // next index to fill, wraps
    logic [15:0] targetCount;                         // count latched at start
    logic        capture;                             // ack seen while requesting

    assign capture = (state == request) && diskAck;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state       <= idle;
            diskReq     <= 1'b0;
            writeEnable <= 1'b0;
            cursor      <= '0;
            targetCount <= '0;
            status      <= '0;
        end else begin
            writeEnable <= 1'b0; // default, pulses on capture only
            case (state)
                idle, finished: begin
                    if (loadStart) begin
                        cursor             <= loadBase;
                        targetCount        <= loadCount;
                        status.busy        <= 1'b1;
                        status.done        <= 1'b0; // fresh run
                        status.wordsLoaded <= '0;
                        state              <= waitRelease; // ack must read low first
                    end
                end
                request: begin
                    if (capture) begin
                        writeEnable        <= 1'b1;
                        cursor             <= cursor + 1'b1; // modulo PROGRAM_DEPTH
                        status.wordsLoaded <= status.wordsLoaded + 16'd1;
                        diskReq            <= 1'b0; // phase 3
                        state              <= waitRelease;
                    end
                end
                waitRelease: begin
                    if (!diskAck) begin
                        if (status.wordsLoaded == targetCount) begin
                            status.busy <= 1'b0;
                            status.done <= 1'b1;
                            state       <= finished;
                        end else begin
                            diskReq <= 1'b1; // next word
                            state   <= request;
                        end
                    end
                end
                default: begin
                    state <= idle;
                end
            endcase
        end
    end

    // word and its slot travel together to memory
    always_ff @(posedge clock) begin
        if (capture) begin
            writeIndex <= cursor;
            writeData  <= diskData;
        end
    end

    // a new request only follows an ack that was already released
    reqAfterAckLow : assert property (
        @(posedge clock) disable iff (reset)
        $rose(diskReq) |-> !$past(diskAck)
    );

endmodule

/* source/programMemory.sv */
`timescale 1ns/1ps

module programMemory (
    input  logic        clock,
    input  logic        writeEnable, // from the loader
    input  logic [fetchPkg::PROGRAM_INDEX_WIDTH-1:0] writeIndex,
    input  logic [31:0] writeData,
    input  logic [fetchPkg::PROGRAM_INDEX_WIDTH-1:0] readIndex, // from fetch
    output logic [31:0] readData
);

    // program store, filled from disk word by word
    logic [31:0] memoryArray [fetchPkg::PROGRAM_DEPTH];

    // write port on the rising edge
    always_ff @(posedge clock) begin
        if (writeEnable) begin
            memoryArray[writeIndex] <= writeData;
        end
    end

    // read port is combinational, fetch registers the result
    // a word written at one edge is visible to the fetch at the next
    assign readData = memoryArray[readIndex];

endmodule

/* src.f */
source/fetchPkg.sv
source/bootControl.sv
source/programLoader.sv
source/programMemory.sv
source/bootRom.sv
source/instructionFetch.sv
source/fetchTop.sv
verification/fetchTopTb.sv

/* verification/fetchTopTb.sv */
`timescale 1ns/1ps

module fetchTopTb;

    logic                  clock;
    logic                  reset;
    logic                  cfgWrite;
    logic [1:0]            cfgAddr;
    logic [31:0]           cfgData;
    logic [31:0]           pc;
    logic                  diskReq;
    logic                  diskAck;
    logic [31:0]           diskData;
    fetchPkg::decodedInstr fields;
    logic                  bootActive;
    fetchPkg::loaderStatus status;

    logic [31:0] model [fetchPkg::PROGRAM_DEPTH]; // words the disk has sent, by index
    logic [7:0]  modelCursor;                      // where the next disk word lands
    logic [31:0] rngState = 32'h7b99_55ac;
    logic        pcValid;                          // current pc is worth checking
    logic [31:0] heldPc;
    logic        heldBoot;
    logic        heldValid;
    logic        prevReq = 1'b0;
    logic        prevAck = 1'b0;
    int          requestCount = 0;                 // rising edges of diskReq

    fetchTop uut (
        .clock(clock), .reset(reset),
        .cfgWrite(cfgWrite), .cfgAddr(cfgAddr), .cfgData(cfgData),
        .pc(pc), .diskReq(diskReq), .diskAck(diskAck), .diskData(diskData),
        .fields(fields), .bootActive(bootActive), .status(status)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] value);
        logic [31:0] x;
        x = value;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        return x;
    endfunction

    // boot words are movi r(a-1), 0 for index a in 1..32, zero elsewhere
    function automatic fetchPkg::decodedInstr expectedFields(
        input logic [31:0] pcValue,
        input logic        boot,
        input logic [31:0] mem [fetchPkg::PROGRAM_DEPTH]
    );
        int                    bootIdx;
        logic [31:0]           word;
        fetchPkg::decodedInstr result;
        word = 32'd0;
        if (boot) begin
            bootIdx = pcValue % fetchPkg::BOOT_DEPTH; // upper pc bits alias
            if (bootIdx >= 1 && bootIdx <= 32) begin
                word[31:26] = fetchPkg::OPCODE_MOVI;
                word[25:21] = 5'(bootIdx - 1);
            end
        end else begin
            word = mem[pcValue % fetchPkg::PROGRAM_DEPTH];
        end
        result.opcode     = word[31:26];
        result.rd         = word[25:21];
        result.rs         = word[20:16];
        result.rt         = word[15:11];
        result.immediate  = word[10:0];
        result.jumpTarget = word[25:0];
        return result;
    endfunction

    task automatic failRun(input string reason);
        $display("%s", reason);
        $display(">>> FAIL");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic checkFields(input string name, input fetchPkg::decodedInstr actual,
                               input fetchPkg::decodedInstr expected);
        if (actual !== expected) begin
            failRun($sformatf("error at %0t: %s is %h, expected %h",
                              $time, name, actual, expected));
        end
    endtask

    task automatic checkStatus(input string name, input fetchPkg::loaderStatus actual,
                               input fetchPkg::loaderStatus expected);
        if (actual !== expected) begin
            failRun($sformatf("error at %0t: %s is %h, expected %h",
                              $time, name, actual, expected));
        end
    endtask

    task automatic checkBit(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            failRun($sformatf("error at %0t: %s is %b, expected %b",
                              $time, name, actual, expected));
        end
    endtask

    task automatic checkCount(input string name, input int actual, input int expected);
        if (actual != expected) begin
            failRun($sformatf("error at %0t: %s is %0d, expected %0d",
                              $time, name, actual, expected));
        end
    endtask

    task automatic holdReset();
        reset = 1'b1;
        repeat (8) @(posedge clock);
        #1;
        reset = 1'b0;
    endtask

    task automatic writeReg(input logic [1:0] addr, input logic [31:0] data);
        @(posedge clock);
        #1;
        cfgWrite = 1'b1;
        cfgAddr  = addr;
        cfgData  = data;
        @(posedge clock);
        #1;
        cfgWrite = 1'b0;
    endtask

    task automatic waitBusy(input logic level);
        while (status.busy !== level) @(negedge clock);
    endtask

    task automatic fetchRange(input int first, input int last);
        for (int p = first; p <= last; p++) begin
            @(posedge clock);
            #1;
            pc      = p;
            pcValid = 1'b1;
        end
        @(posedge clock);
        #1;
        pcValid = 1'b0;
        repeat (2) @(negedge clock); // last fetch still in flight
    endtask

    task automatic checkResetState();
        checkBit("bootActive", bootActive, 1'b1);
        checkBit("diskReq", diskReq, 1'b0);
        checkStatus("status", status, fetchPkg::loaderStatus'('0));
    endtask

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    // fields after an edge belongs to the pc and boot flag held before it
    always @(negedge clock) begin
        if (heldValid) begin
            checkFields("fields", fields, expectedFields(heldPc, heldBoot, model));
        end
        heldValid = pcValid && !reset;
        heldPc    = pc;
        heldBoot  = bootActive;
    end

    always @(negedge clock) begin
        if (diskReq && !prevReq) begin
            requestCount++;
            if (prevAck) failRun("diskReq rose while diskAck was still high");
        end
        prevReq = diskReq;
        prevAck = diskAck;
    end

    // disk side of the four-phase link
    initial begin : diskResponder
        int delay;
        forever begin
            @(negedge clock);
            if (diskReq && !diskAck) begin
                rngState = xorshift(rngState);
                delay    = rngState % 4;          // 0 to 3 idle cycles
                repeat (delay) @(negedge clock);
                @(posedge clock);
                #1;
                rngState           = xorshift(rngState);
                diskData           = rngState;
                diskAck            = 1'b1;
                model[modelCursor] = rngState;
                modelCursor++;                    // wraps at 256
                do @(negedge clock); while (diskReq);
                @(posedge clock);
                #1;
                diskAck = 1'b0;
            end
        end
    end

    initial begin : watchdog
        int limitCycles;
        limitCycles = (40 + 12 + 30) * 200 + 2000; // words of all loads
        repeat (limitCycles) @(posedge clock);
        failRun("timeout: load or fetch never finished");
    end

    initial begin
        reset = 1'b1;
        cfgWrite = 1'b0;
        cfgAddr = 2'd0;
        cfgData = 32'd0;
        pc = 32'd0;
        pcValid = 1'b0;
        diskAck = 1'b0;
        diskData = 32'd0;
        modelCursor = 8'd0;
        holdReset();
        @(negedge clock);
        checkResetState();
        fetchRange(0, 40);                        // boot rom incl. zero tail

        modelCursor = 8'd10;
        writeReg(fetchPkg::CFG_LOAD_BASE, 32'd10);
        writeReg(fetchPkg::CFG_LOAD_COUNT, 32'd40);
        writeReg(fetchPkg::CFG_CONTROL, 32'd1 << fetchPkg::CTRL_START_LOAD);
        waitBusy(1'b1);
        writeReg(fetchPkg::CFG_CONTROL, 32'd1 << fetchPkg::CTRL_START_LOAD); // ignored
        waitBusy(1'b0);
        checkStatus("status", status, fetchPkg::loaderStatus'({1'b0, 1'b1, 16'd40}));
        checkCount("diskReq rises", requestCount, 40);

        writeReg(fetchPkg::CFG_LOAD_COUNT, 32'd0);
        writeReg(fetchPkg::CFG_CONTROL, 32'd1 << fetchPkg::CTRL_START_LOAD); // zero count
        repeat (10) @(negedge clock);
        checkStatus("status", status, fetchPkg::loaderStatus'({1'b0, 1'b1, 16'd40}));
        checkCount("diskReq rises", requestCount, 40);

        writeReg(fetchPkg::CFG_CONTROL, 32'd1 << fetchPkg::CTRL_END_BOOT);
        @(negedge clock);
        checkBit("bootActive", bootActive, 1'b0);
        fetchRange(10, 49);

        modelCursor = 8'd250;
        writeReg(fetchPkg::CFG_LOAD_BASE, 32'd250);
        writeReg(fetchPkg::CFG_LOAD_COUNT, 32'd12);
        writeReg(fetchPkg::CFG_CONTROL, 32'd1 << fetchPkg::CTRL_START_LOAD);
        waitBusy(1'b1);
        waitBusy(1'b0);
        checkStatus("status", status, fetchPkg::loaderStatus'({1'b0, 1'b1, 16'd12}));
        checkCount("diskReq rises", requestCount, 52);
        fetchRange(250, 255);
        fetchRange(0, 5);
        fetchRange(506, 517);                     // aliases of 250..255 and 0..5

        modelCursor = 8'd0;
        writeReg(fetchPkg::CFG_LOAD_BASE, 32'd0);
        writeReg(fetchPkg::CFG_LOAD_COUNT, 32'd30);
        writeReg(fetchPkg::CFG_CONTROL, 32'd1 << fetchPkg::CTRL_START_LOAD);
        waitBusy(1'b1);
        while (status.wordsLoaded < 16'd3) @(negedge clock);
        @(posedge clock);
        #1;
        holdReset();                              // mid-load
        @(negedge clock);
        checkResetState();
        fetchRange(0, 5);

        $display(">>> PASS");
        $finish;
    end

endmodule
